//--- src.f
sram_pkg.sv
port_req_if.sv
write_queue.sv
bank_arbiter.sv
sram_banks.sv
banked_sram_top.sv
tb_banked_sram.sv

//--- Bender.yml
package:
  name: banked_sram

sources:
  - sram_pkg.sv
  - port_req_if.sv
  - write_queue.sv
  - bank_arbiter.sv
  - sram_banks.sv
  - banked_sram_top.sv
  - target: simulation
    files:
      - tb_banked_sram.sv

//--- tb_banked_sram.sv
module tb_banked_sram import sram_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 100;
    localparam int mem_words  = num_banks * bank_depth;

    ////////////////////////////////////////////////////////////
    // Cycle budget
    ////////////////////////////////////////////////////////////

    // Per test the stimulus, the 4N+2 drain bound plus one and the read back
    localparam int reset_cycles      = 6;
    localparam int latency_cycles    = 2 * (4 * 1 + 3) + 8;
    localparam int mapping_cycles    = 64 + (4 * 64 + 3) + 64;
    localparam int concurrent_cycles = 200 + (4 * 200 + 3) + 800;
    localparam int ordering_cycles   = 8 + (4 * 8 + 3) + 32;
    localparam int full_cycles       = 300 + (4 * 300 + 3) + bank_depth;
    localparam int margin_cycles     = 200;
    localparam int watchdog_cycles   = reset_cycles + latency_cycles + mapping_cycles
                                     + concurrent_cycles + ordering_cycles + full_cycles
                                     + margin_cycles;

    logic                                 clk;
    logic                                 reset;
    sram_addr_u [num_ports-1:0]           addr;
    logic [num_ports-1:0]                 we;
    logic [num_ports-1:0][data_width-1:0] wd;
    logic [num_ports-1:0][data_width-1:0] rd;
    logic [num_ports-1:0]                 full;

    // Reference model
    logic [data_width-1:0] model_mem [mem_words];
    bit                    used      [mem_words];
    int                    pending   [num_ports];

    integer seed;

    banked_sram_top i_banked_sram_top (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .we    (we),
        .wd    (wd),
        .rd    (rd),
        .full  (full)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [data_width-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic start_test();
        for (int a = 0; a < mem_words; a++) begin
            used[a] = 1'b0;
        end
        for (int p = 0; p < num_ports; p++) begin
            pending[p] = 0;
        end
    endtask

    // Strobes drop on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        we = '0;
    endtask

    // Fresh address in bank bank_sel or in any bank when negative
    task automatic alloc_addr(input int bank_sel, output int a);
        do begin
            a = $random(seed) & (mem_words - 1);
            if (bank_sel >= 0) begin
                a = (a & ~(num_banks - 1)) | bank_sel;
            end
        end while (used[a]);
        used[a] = 1'b1;
    endtask

    // Level of full now decides acceptance since it only moves at rising edges
    task automatic issue(input int p, input int a, input logic [data_width-1:0] d);
        we[p]        = 1'b1;
        addr[p].flat = a[addr_width-1:0];
        wd[p]        = d;
        if (!full[p]) begin
            model_mem[a] = d;
            used[a]      = 1'b1;
            pending[p]++;
        end
    endtask

    task automatic drain();
        int most;
        most = 0;
        for (int p = 0; p < num_ports; p++) begin
            if (pending[p] > most) begin
                most = pending[p];
            end
        end
        next_cycle();
        repeat (4 * most + 3) @(posedge clk);
        for (int p = 0; p < num_ports; p++) begin
            pending[p] = 0;
        end
    endtask

    // Port p reads the entry p places after i and every address passes every port
    task automatic check_touched(input string name);
        int list[$];
        int n;
        int a;
        for (int j = 0; j < mem_words; j++) begin
            if (used[j]) begin
                list.push_back(j);
            end
        end
        n = list.size();
        for (int i = 0; i < n; i++) begin
            next_cycle();
            for (int p = 0; p < num_ports; p++) begin
                a            = list[(i + p) % n];
                addr[p].flat = a[addr_width-1:0];
            end
            #(clk_period / 4);
            for (int p = 0; p < num_ports; p++) begin
                check_value(name, model_mem[list[(i + p) % n]], rd[p]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_latency();
        int a;
        int p;
        logic [data_width-1:0] old_val;
        logic [data_width-1:0] new_val;
        start_test();
        alloc_addr(-1, a);
        p       = $random(seed) & (num_ports - 1);
        old_val = rand_word();
        new_val = ~old_val;
        // Give the word a known value first since arrays power up unknown
        next_cycle();
        issue(p, a, old_val);
        drain();
        next_cycle();
        issue(p, a, new_val);
        for (int q = 0; q < num_ports; q++) begin
            addr[q].flat = a[addr_width-1:0];
        end
        next_cycle();
        for (int q = 0; q < num_ports; q++) begin
            check_value("latency_edge_k", old_val, rd[q]);
        end
        next_cycle();
        for (int q = 0; q < num_ports; q++) begin
            check_value("latency_edge_k1", old_val, rd[q]);
        end
        next_cycle();
        for (int q = 0; q < num_ports; q++) begin
            check_value("latency_edge_k2", new_val, rd[q]);
        end
    endtask

    task automatic test_bank_mapping();
        int a;
        start_test();
        for (int i = 0; i < 64; i++) begin
            next_cycle();
            alloc_addr(i % num_banks, a);
            issue($random(seed) & (num_ports - 1), a, rand_word());
        end
        drain();
        check_touched("bank_mapping");
    endtask

    task automatic test_concurrent();
        int a;
        start_test();
        for (int c = 0; c < 200; c++) begin
            next_cycle();
            for (int p = 0; p < num_ports; p++) begin
                alloc_addr(-1, a);
                issue(p, a, rand_word());
            end
        end
        drain();
        check_touched("concurrent_ports");
    endtask

    // Port 3 loses every grant while ports 0 to 2 hold its bank
    task automatic test_ordering();
        int b;
        int a;
        int target;
        logic [data_width-1:0] first_val;
        start_test();
        b = $random(seed) & (num_banks - 1);
        alloc_addr(b, target);
        first_val = rand_word();
        for (int c = 0; c < 8; c++) begin
            next_cycle();
            for (int q = 0; q < num_ports - 1; q++) begin
                alloc_addr(b, a);
                issue(q, a, rand_word());
            end
            if (c == 0) begin
                issue(num_ports - 1, target, first_val);
            end
            if (c == 1) begin
                issue(num_ports - 1, target, ~first_val);
            end
        end
        drain();
        check_touched("per_port_ordering");
    endtask

    task automatic test_full_drop();
        int  c;
        int  a;
        int  extra;
        bit  seen_full;
        start_test();
        c         = 0;
        extra     = 0;
        seen_full = 1'b0;
        while (c < 300 && extra < 4) begin
            next_cycle();
            if (full[num_ports-1]) begin
                seen_full = 1'b1;
            end
            for (int p = 0; p < num_ports; p++) begin
                // Bank 0 only with the low index bits keeping the ports apart
                a = ((c % 128) * num_ports + p) * num_banks;
                issue(p, a, rand_word());
            end
            if (seen_full) begin
                extra++;
            end
            c++;
        end
        assert (seen_full) else begin
            $display("full[3] did not rise within 300 cycles of bank 0 writes");
            $display("Done: errors found");
            $fatal(1);
        end
        drain();
        check_touched("queue_full_drop");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        seed  = 32'ha4d8f128;
        reset = 1'b1;
        we    = '0;
        wd    = '0;
        addr  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("reset_state", '0, data_width'(full));
        test_latency();
        test_bank_mapping();
        test_concurrent();
        test_ordering();
        test_full_drop();
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles and the tests did not finish",
                 watchdog_cycles);
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

//--- banked_sram_top.sv
module banked_sram_top import sram_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,

    input  sram_addr_u [num_ports-1:0]           addr,
    input  logic [num_ports-1:0]                 we,
    input  logic [num_ports-1:0][data_width-1:0] wd,
    output logic [num_ports-1:0][data_width-1:0] rd,
    output logic [num_ports-1:0]                 full
);

    // Queue heads towards the arbiter
    port_req_if req_if [num_ports] ();

    // Granted writes, one slot per bank
    logic [num_banks-1:0]                 bank_we;
    logic [num_banks-1:0][index_bits-1:0] bank_index;
    logic [num_banks-1:0][data_width-1:0] bank_data;

    ////////////////////////////////////////////////////////////
    // Write queues
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        write_queue i_write_queue (
            .clk   (clk),
            .reset (reset),
            .we    (we[p]),
            .addr  (addr[p]),
            .wd    (wd[p]),
            .full  (full[p]),
            .req   (req_if[p])
        );
    end

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////

    bank_arbiter i_bank_arbiter (
        .req0       (req_if[0]),
        .req1       (req_if[1]),
        .req2       (req_if[2]),
        .req3       (req_if[3]),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_data  (bank_data)
    );

    ////////////////////////////////////////////////////////////
    // Storage and reads
    ////////////////////////////////////////////////////////////

    // Read addresses bypass the queues entirely
    sram_banks i_sram_banks (
        .clk        (clk),
        .reset      (reset),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_data  (bank_data),
        .rd_addr    (addr),
        .rd         (rd)
    );

endmodule

//--- sram_banks.sv
module sram_banks import sram_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [num_banks-1:0]                 bank_we,
    input  logic [num_banks-1:0][index_bits-1:0] bank_index,
    input  logic [num_banks-1:0][data_width-1:0] bank_data,

    input  sram_addr_u [num_ports-1:0]           rd_addr,
    output logic [num_ports-1:0][data_width-1:0] rd
);

    // Bank b holds every word whose low address bits equal b
    logic [data_width-1:0] mem [num_banks][bank_depth];

    // One-deep write stage per bank
    logic [num_banks-1:0]                 wr_valid;
    logic [num_banks-1:0][index_bits-1:0] wr_index;
    logic [num_banks-1:0][data_width-1:0] wr_data;

    ////////////////////////////////////////////////////////////
    // Write registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_valid <= '0;
        end else begin
            wr_valid <= bank_we;
        end
    end

    // Payload only matters while the valid bit is set
    always_ff @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (bank_we[b]) begin
                wr_index[b] <= bank_index[b];
                wr_data[b]  <= bank_data[b];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bank arrays
    ////////////////////////////////////////////////////////////

    // Register drains into its array one cycle after the grant
    always_ff @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (wr_valid[b]) begin
                mem[b][wr_index[b]] <= wr_data[b];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read multiplexers
    ////////////////////////////////////////////////////////////

    // Combinational, no bypass from the write stage
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            rd[p] = mem[rd_addr[p].fields.bank][rd_addr[p].fields.index];
        end
    end

endmodule

//--- bank_arbiter.sv
module bank_arbiter import sram_pkg::*; (
    port_req_if.arbiter req0,
    port_req_if.arbiter req1,
    port_req_if.arbiter req2,
    port_req_if.arbiter req3,

    output logic [num_banks-1:0]                 bank_we,
    output logic [num_banks-1:0][index_bits-1:0] bank_index,
    output logic [num_banks-1:0][data_width-1:0] bank_data
);

    // Queue heads gathered into arrays
    logic       [num_ports-1:0]                 head_valid;
    sram_addr_u [num_ports-1:0]                 head_addr;
    logic       [num_ports-1:0][data_width-1:0] head_data;

    // One-hot winner per bank
    logic [num_banks-1:0][num_ports-1:0] grant;
    logic [num_ports-1:0]                pop;

    ////////////////////////////////////////////////////////////
    // Head collection
    ////////////////////////////////////////////////////////////

    assign head_valid = {req3.valid, req2.valid, req1.valid, req0.valid};
    assign head_addr  = {req3.addr, req2.addr, req1.addr, req0.addr};
    assign head_data  = {req3.data, req2.data, req1.data, req0.data};

    assign req0.pop = pop[0];
    assign req1.pop = pop[1];
    assign req2.pop = pop[2];
    assign req3.pop = pop[3];

    ////////////////////////////////////////////////////////////
    // Fixed priority per bank
    ////////////////////////////////////////////////////////////

    // Ports scanned from highest to lowest, so the last hit wins
    // and port 0 ends up with top priority
    always_comb begin
        bank_we    = '0;
        bank_index = '0;
        bank_data  = '0;
        grant      = '0;
        for (int b = 0; b < num_banks; b++) begin
            for (int p = num_ports - 1; p >= 0; p--) begin
                if (head_valid[p] && (head_addr[p].fields.bank == bank_bits'(b))) begin
                    bank_we[b]    = 1'b1;
                    bank_index[b] = head_addr[p].fields.index;
                    bank_data[b]  = head_data[p];
                    grant[b]      = '0;
                    grant[b][p]   = 1'b1;
                end
            end
        end
    end

    // Each head targets one bank, so at most one grant per port
    always_comb begin
        pop = '0;
        for (int b = 0; b < num_banks; b++) begin
            pop = pop | grant[b];
        end
    end

endmodule

//--- write_queue.sv
module write_queue import sram_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  sram_addr_u            addr,
    input  logic [data_width-1:0] wd,
    output logic                  full,
    port_req_if.queue             req
);

    // Entry storage, address and data side by side
    logic [addr_width-1:0] addr_mem [queue_depth];
    logic [data_width-1:0] data_mem [queue_depth];

    logic [queue_ptr_bits-1:0] wr_ptr;
    logic [queue_ptr_bits-1:0] rd_ptr;
    logic [queue_ptr_bits:0]   count;

    logic push;
    logic pop;

    // A strobe while full is lost
    assign push = we && !full;
    assign pop  = req.pop && req.valid;

    assign full = (count == queue_depth);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= addr.flat;
            data_mem[wr_ptr] <= wd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead head
    assign req.valid     = (count != '0);
    assign req.addr.flat = addr_mem[rd_ptr];
    assign req.data      = data_mem[rd_ptr];

endmodule

//--- port_req_if.sv
interface port_req_if import sram_pkg::*; ();

    // Head of one write queue
    logic                  valid;
    sram_addr_u            addr;
    logic [data_width-1:0] data;

    // Removes the head at the next rising edge
    logic                  pop;

    modport queue (
        output valid,
        output addr,
        output data,
        input  pop
    );

    modport arbiter (
        input  valid,
        input  addr,
        input  data,
        output pop
    );

endinterface

//--- sram_pkg.sv
package sram_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////

    localparam int num_ports  = 4;
    localparam int num_banks  = 4;
    localparam int data_width = 32;

    // Word address split, bank in the low bits
    localparam int bank_bits  = 2;
    localparam int index_bits = 9;
    localparam int addr_width = bank_bits + index_bits;
    localparam int bank_depth = 1 << index_bits;

    // Per-port write queue
    localparam int queue_depth    = 256;
    localparam int queue_ptr_bits = $clog2(queue_depth);

    ////////////////////////////////////////////////////////////
    // Address views
    ////////////////////////////////////////////////////////////

    // Index on top, bank select in the two low bits
    typedef struct packed {
        logic [index_bits-1:0] index;
        logic [bank_bits-1:0]  bank;
    } sram_addr_fields_t;

    // Same word seen as a flat address or as bank and index
    typedef union packed {
        logic [addr_width-1:0] flat;
        sram_addr_fields_t     fields;
    } sram_addr_u;

endpackage
